// ==== zc_seq_pkg.sv ====
// Shared types, constants and helper functions for the Zc push/pop sequencer
// Every sequencer module imports this package inside its body
// Port types in module headers refer to it through scoped names

package zc_seq_pkg;

  //////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////

  // Base register set, RV32E only has x0..x15
  typedef enum logic {
    RV32I = 1'b0,
    RV32E = 1'b1
  } rv_base_e;

  // Sequenced instructions recognised by the decoder
  typedef enum logic [2:0] {
    OP_INVALID = 3'd0,
    OP_PUSH    = 3'd1,
    OP_POP     = 3'd2,
    OP_POPRET  = 3'd3,
    OP_POPRETZ = 3'd4,
    OP_MVSA01  = 3'd5,
    OP_MVA01S  = 3'd6
  } seq_op_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_PUSH  = 3'd1,
    S_POP   = 3'd2,
    S_DMOVE = 3'd3,
    S_RA    = 3'd4,
    S_SP    = 3'd5,
    S_A0    = 3'd6,
    S_RET   = 3'd7
  } seq_state_e;

  // Beat index within one sequence, longest run is 16 beats
  typedef logic [3:0] seq_cnt_t;

  // Signed I/S-type immediate for stack offsets
  typedef logic signed [11:0] stack_adj_t;

  // Decode result shared by FSM and emitter
  typedef struct packed {
    seq_op_e    op;
    logic [3:0] sregs_saved;
    stack_adj_t total_stack_adj;
    logic [2:0] r1s;
    logic [2:0] r2s;
  } seq_decode_t;

  //////////////////////////////////////////////////
  // RV32 encoding constants
  //////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR  = 7'h67;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  localparam logic [2:0] FUNCT3_W    = 3'b010;
  localparam logic [2:0] FUNCT3_ADDI = 3'b000;

  // s0/s1 live in x8/x9, s2..s11 in x18..x27
  function automatic logic [4:0] sn_to_regnum(input logic [3:0] sn);
    logic [4:0] regnum;
    if (sn < 4'd2) begin
      regnum = {4'b0100, sn[0]};
    end else begin
      regnum = 5'd16 + {1'b0, sn};
    end
    return regnum;
  endfunction

  // rlist 15 saves s0..s11, skipping the s0..s10 case
  function automatic logic [3:0] sregs_from_rlist(input logic [3:0] rlist);
    logic [3:0] sregs;
    if (rlist == 4'd15) begin
      sregs = 4'd12;
    end else if (rlist >= 4'd4) begin
      sregs = rlist - 4'd4;
    end else begin
      sregs = 4'd0;
    end
    return sregs;
  endfunction

  // Space for the s registers plus ra, rounded up to 16 bytes
  function automatic stack_adj_t stack_adj_base(input logic [3:0] sregs);
    logic [6:0] bytes;
    bytes = {1'b0, sregs + 4'd1, 2'b00};
    bytes = bytes + 7'd15;
    return {5'b00000, bytes[6:4], 4'b0000};
  endfunction

endpackage

// ==== zc_seq_decoder.sv ====
// Combinational decoder for the Zc push/pop and double-move encodings
// Classifies a 16-bit word, applies the RV32I/RV32E legality rules
// and fills the decode struct used by the FSM and the emitter

`timescale 1ns/1ps

module zc_seq_decoder #(
  parameter zc_seq_pkg::rv_base_e ARCH = zc_seq_pkg::RV32I
) (
  input  logic [15:0]             instr_i,
  output zc_seq_pkg::seq_decode_t dec_o
);

  import zc_seq_pkg::*;

  // Instruction fields
  logic [3:0] rlist;
  logic [1:0] spimm;
  logic [2:0] r1s;
  logic [2:0] r2s;

  // Legality and classification
  logic       is_zc_group;
  logic       rlist_legal;
  logic       mva01s_legal;
  logic       mvsa01_legal;
  seq_op_e    op;
  logic [3:0] sregs;

  assign rlist = instr_i[7:4];
  assign spimm = instr_i[3:2];
  assign r1s   = instr_i[9:7];
  assign r2s   = instr_i[4:2];

  // All sequenced instructions sit in quadrant 2 with funct3 101
  assign is_zc_group = (instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101);

  // rlist 0..3 is reserved
  // RV32E has no s2 and up, so rlist stops at 6
  assign rlist_legal = (ARCH == RV32E) ? (rlist >= 4'd4) && (rlist < 4'd7) :
                                         (rlist >= 4'd4);

  // mva01s may read the same s register twice
  assign mva01s_legal = (ARCH == RV32E) ? (r1s < 3'd2) && (r2s < 3'd2) : 1'b1;

  // mvsa01 must write two different s registers
  assign mvsa01_legal = (r1s != r2s) &&
                        ((ARCH == RV32I) || ((r1s < 3'd2) && (r2s < 3'd2)));

  //////////////////////////////////////////////////
  // Opcode classification
  //////////////////////////////////////////////////

  always_comb begin
    op = OP_INVALID;
    if (is_zc_group) begin
      case (instr_i[12:10])
        // Double moves, selected by bits 6:5
        3'b011: begin
          if ((instr_i[6:5] == 2'b11) && mva01s_legal) begin
            op = OP_MVA01S;
          end else if ((instr_i[6:5] == 2'b01) && mvsa01_legal) begin
            op = OP_MVSA01;
          end
        end
        // push and pop
        3'b110: begin
          if ((instr_i[9:8] == 2'b00) && rlist_legal) begin
            op = OP_PUSH;
          end else if ((instr_i[9:8] == 2'b10) && rlist_legal) begin
            op = OP_POP;
          end
        end
        // Returning pops
        3'b111: begin
          if ((instr_i[9:8] == 2'b00) && rlist_legal) begin
            op = OP_POPRETZ;
          end else if ((instr_i[9:8] == 2'b10) && rlist_legal) begin
            op = OP_POPRET;
          end
        end
        default: begin
          op = OP_INVALID;
        end
      endcase
    end
  end

  assign sregs = sregs_from_rlist(rlist);

  // Total adjustment adds spimm blocks of 16 bytes on top of the base
  always_comb begin
    dec_o.op              = op;
    dec_o.sregs_saved     = sregs;
    dec_o.total_stack_adj = stack_adj_base(sregs) + {6'b000000, spimm, 4'b0000};
    dec_o.r1s             = r1s;
    dec_o.r2s             = r2s;
  end

endmodule

// ==== zc_seq_counter.sv ====
// Beat counter for the sequencer
// Counts transferred beats and restarts at zero for the next sequence

`timescale 1ns/1ps

module zc_seq_counter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 count_inc_i,
  input  logic                 count_clr_i,
  output zc_seq_pkg::seq_cnt_t count_o
);

  import zc_seq_pkg::*;

  seq_cnt_t count_q;

  //////////////////////////////////////////////////
  // Count register
  //////////////////////////////////////////////////

  // Clear wins over increment, so a last beat or kill always restarts at 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (count_clr_i) begin
      count_q <= '0;
    end else if (count_inc_i) begin
      count_q <= count_q + 4'd1;
    end
  end

  assign count_o = count_q;

endmodule

// ==== zc_seq_fsm.sv ====
// Sequencing FSM for the Zc push/pop and double-move expansion
// Drives the valid/ready handshake, the first/last flags and the counter controls
// State advances only on a transferred beat and falls back to idle on kill

`timescale 1ns/1ps

module zc_seq_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  zc_seq_pkg::seq_decode_t dec_i,
  input  zc_seq_pkg::seq_cnt_t    count_i,
  input  logic                    valid_i,
  input  logic                    ready_i,
  input  logic                    kill_i,
  output zc_seq_pkg::seq_state_e  state_o,
  output logic                    valid_o,
  output logic                    ready_o,
  output logic                    first_o,
  output logic                    last_o,
  output logic                    count_inc_o,
  output logic                    count_clr_o
);

  import zc_seq_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       xfer;
  logic       plain_pushpop;
  logic       sregs_done;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Output is offered only for legal words and never while killed
  assign valid_o = valid_i && (dec_i.op != OP_INVALID) && !kill_i;
  assign xfer    = valid_o && ready_i;

  // push and pop end at the sp adjust, the returning pops go on
  assign plain_pushpop = (dec_i.op == OP_PUSH) || (dec_i.op == OP_POP);
  assign sregs_done    = (count_i == dec_i.sregs_saved - 4'd1);

  assign first_o = (state_q == S_IDLE);
  assign last_o  = (state_q == S_DMOVE) || (state_q == S_RET) ||
                   ((state_q == S_SP) && plain_pushpop);

  // Input word is consumed on the last beat, when dropped as illegal, or on kill
  assign ready_o = (xfer && last_o) || !valid_o || kill_i;

  assign count_inc_o = xfer && !last_o;
  assign count_clr_o = (xfer && last_o) || kill_i;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if ((dec_i.op == OP_MVSA01) || (dec_i.op == OP_MVA01S)) begin
          state_d = S_DMOVE;
        end else if (dec_i.op != OP_INVALID) begin
          // First beat already handled the top s register or ra
          if (dec_i.sregs_saved > 4'd1) begin
            state_d = (dec_i.op == OP_PUSH) ? S_PUSH : S_POP;
          end else if (dec_i.sregs_saved == 4'd1) begin
            state_d = S_RA;
          end else begin
            state_d = S_SP;
          end
        end
      end
      S_PUSH, S_POP: begin
        if (sregs_done) begin
          state_d = S_RA;
        end
      end
      S_RA:    state_d = S_SP;
      S_SP: begin
        if (dec_i.op == OP_POPRETZ) begin
          state_d = S_A0;
        end else if (dec_i.op == OP_POPRET) begin
          state_d = S_RET;
        end else begin
          state_d = S_IDLE;
        end
      end
      S_A0:    state_d = S_RET;
      S_RET:   state_d = S_IDLE;
      S_DMOVE: state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  // Hold under back-pressure, restart on kill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else if (kill_i) begin
      state_q <= S_IDLE;
    end else if (xfer) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

// ==== zc_seq_emitter.sv ====
// Instruction emitter for the sequencer
// Builds the current 32-bit RV32 word from FSM state, decode result and beat index
// Purely combinational, so the word stays stable while its inputs hold

`timescale 1ns/1ps

module zc_seq_emitter (
  input  zc_seq_pkg::seq_state_e  state_i,
  input  zc_seq_pkg::seq_decode_t dec_i,
  input  zc_seq_pkg::seq_cnt_t    count_i,
  output logic [31:0]             instr_o
);

  import zc_seq_pkg::*;

  logic       is_load;
  logic       is_mvsa;
  logic [3:0] sreg_idx;
  logic [4:0] sreg_num;
  logic [4:0] first_reg;
  logic [4:0] mv_r1;
  logic [4:0] mv_r2;
  stack_adj_t step;
  stack_adj_t offset;

  //////////////////////////////////////////////////
  // Encoding helpers
  //////////////////////////////////////////////////

  // sw rs2, imm(sp)
  function automatic logic [31:0] enc_store(input logic [4:0] rs2, input stack_adj_t imm);
    return {imm[11:5], rs2, REG_SP, FUNCT3_W, imm[4:0], OPCODE_STORE};
  endfunction

  // lw rd, imm(sp)
  function automatic logic [31:0] enc_load(input logic [4:0] rd, input stack_adj_t imm);
    return {imm, REG_SP, FUNCT3_W, rd, OPCODE_LOAD};
  endfunction

  // addi rd, rs1, imm
  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input stack_adj_t imm);
    return {imm, rs1, FUNCT3_ADDI, rd, OPCODE_OPIMM};
  endfunction

  assign is_load = (dec_i.op == OP_POP) || (dec_i.op == OP_POPRET) ||
                   (dec_i.op == OP_POPRETZ);
  assign is_mvsa = (dec_i.op == OP_MVSA01);

  // s registers go out highest first
  assign sreg_idx  = dec_i.sregs_saved - count_i - 4'd1;
  assign sreg_num  = sn_to_regnum(sreg_idx);
  // With no s registers the first beat already moves ra
  assign first_reg = (dec_i.sregs_saved == 4'd0) ? REG_RA : sreg_num;

  assign mv_r1 = sn_to_regnum({1'b0, dec_i.r1s});
  assign mv_r2 = sn_to_regnum({1'b0, dec_i.r2s});

  // Slots run downward from -4, pops rewind by the total first
  assign step   = {5'b00000, {1'b0, count_i} + 5'd1, 2'b00};
  assign offset = is_load ? dec_i.total_stack_adj - step : -step;

  //////////////////////////////////////////////////
  // Instruction select
  //////////////////////////////////////////////////

  always_comb begin
    instr_o = '0;
    case (state_i)
      S_IDLE: begin
        if (dec_i.op == OP_PUSH) begin
          instr_o = enc_store(first_reg, offset);
        end else if (is_load) begin
          instr_o = enc_load(first_reg, offset);
        end else if (is_mvsa) begin
          instr_o = enc_addi(mv_r1, REG_A0, '0);
        end else if (dec_i.op == OP_MVA01S) begin
          instr_o = enc_addi(REG_A0, mv_r1, '0);
        end
      end
      S_PUSH:  instr_o = enc_store(sreg_num, offset);
      S_POP:   instr_o = enc_load(sreg_num, offset);
      S_RA:    instr_o = is_load ? enc_load(REG_RA, offset) : enc_store(REG_RA, offset);
      S_SP: begin
        // Pops release the frame, push allocates it
        if (is_load) begin
          instr_o = enc_addi(REG_SP, REG_SP, dec_i.total_stack_adj);
        end else begin
          instr_o = enc_addi(REG_SP, REG_SP, -dec_i.total_stack_adj);
        end
      end
      // popretz clears the return value
      S_A0:    instr_o = enc_addi(REG_A0, REG_ZERO, '0);
      // jalr x0, 0(ra)
      S_RET:   instr_o = {12'h000, REG_RA, 3'b000, REG_ZERO, OPCODE_JALR};
      S_DMOVE: instr_o = is_mvsa ? enc_addi(mv_r2, REG_A1, '0) : enc_addi(REG_A1, mv_r2, '0);
      default: instr_o = '0;
    endcase
  end

endmodule

// ==== zc_sequencer.sv ====
// Top level of the Zc push/pop and double-move sequencer
// Takes one 16-bit compressed word and emits its 32-bit expansion beat by beat
// ARCH selects the RV32I or RV32E legality rules

`timescale 1ns/1ps

module zc_sequencer #(
  parameter zc_seq_pkg::rv_base_e ARCH = zc_seq_pkg::RV32I
) (
  input  logic        clk,
  input  logic        rst_n,
  // Compressed input side
  input  logic [15:0] instr_i,
  input  logic        valid_i,
  output logic        ready_o,
  // Expanded output side
  output logic [31:0] instr_o,
  output logic        valid_o,
  input  logic        ready_i,
  output logic        first_o,
  output logic        last_o,
  // Drops the running sequence
  input  logic        kill_i
);

  import zc_seq_pkg::*;

  seq_decode_t dec;
  seq_state_e  state;
  seq_cnt_t    count;
  logic        count_inc;
  logic        count_clr;

  //////////////////////////////////////////////////
  // Decode, control, count and emit
  //////////////////////////////////////////////////

  zc_seq_decoder #(
    .ARCH (ARCH)
  ) i_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  zc_seq_fsm i_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_i       (dec),
    .count_i     (count),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .kill_i      (kill_i),
    .state_o     (state),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .first_o     (first_o),
    .last_o      (last_o),
    .count_inc_o (count_inc),
    .count_clr_o (count_clr)
  );

  zc_seq_counter i_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .count_inc_i (count_inc),
    .count_clr_i (count_clr),
    .count_o     (count)
  );

  zc_seq_emitter i_emitter (
    .state_i (state),
    .dec_i   (dec),
    .count_i (count),
    .instr_o (instr_o)
  );

endmodule

// ==== tb_zc_sequencer.sv ====
// Self-checking testbench for the Zc push/pop and double-move sequencer
// Feeds compressed words, applies random back-pressure and checks every beat
// against an expansion model built from the Zcmp rules

`timescale 1ns/1ps

module tb_zc_sequencer;

  localparam int          TIMEOUT = 200;
  localparam logic [31:0] SEED    = 32'h8f4d;

  logic        clk     = 1'b0;
  logic        rst_n;
  logic [15:0] instr_i;
  logic        valid_i;
  logic        ready_o;
  logic [31:0] instr_o;
  logic        valid_o;
  logic        ready_i = 1'b0;
  logic        first_o;
  logic        last_o;
  logic        kill_i;

  // Expected expansion of the word on the input
  logic [31:0] exp_mem [0:15];
  int          exp_len;
  logic        exp_legal;
  string       test_name;
  int          beat;

  logic [31:0] bp_lfsr   = SEED;
  logic [31:0] stim_lfsr = SEED;

  int value_errs;
  int flag_errs;
  int hs_errs;
  int timeout_errs;

  zc_sequencer #(
    .ARCH (zc_seq_pkg::RV32I)
  ) i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr_i (instr_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .instr_o (instr_o),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .first_o (first_o),
    .last_o  (last_o),
    .kill_i  (kill_i)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random bits and RV32 encoders
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], stim_lfsr[31]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
  endtask

  // s0/s1 are x8/x9, s2..s11 are x18..x27
  function automatic logic [4:0] sreg_num(input int sn);
    return (sn < 2) ? 5'(8 + sn) : 5'(16 + sn);
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input int off);
    logic [11:0] imm;
    imm = off[11:0];
    return {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] lw_word(input logic [4:0] rd, input int off);
    logic [11:0] imm;
    imm = off[11:0];
    return {imm, 5'd2, 3'b010, rd, 7'h03};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input int off);
    logic [11:0] imm;
    imm = off[11:0];
    return {imm, rs1, 3'b000, rd, 7'h13};
  endfunction

  // Quadrant 2 compressed words with funct3 101
  function automatic logic [15:0] pp_word(input logic [2:0] grp, input logic [1:0] sub,
                                          input logic [3:0] rlist, input logic [1:0] spimm);
    return {3'b101, grp, sub, rlist, spimm, 2'b10};
  endfunction

  function automatic logic [15:0] mv_word(input logic [1:0] sel, input logic [2:0] r1s,
                                          input logic [2:0] r2s);
    return {6'b101011, r1s, sel, r2s, 2'b10};
  endfunction

  //////////////////////////////////////////////////
  // Expansion model
  //////////////////////////////////////////////////

  function automatic void push_exp(input logic [31:0] word);
    exp_mem[exp_len] = word;
    exp_len++;
  endfunction

  function automatic void build_expected(input logic [15:0] w);
    logic [2:0] grp;
    logic [2:0] r1s;
    logic [2:0] r2s;
    logic       is_pop;
    int         sregs;
    int         total;
    grp     = w[12:10];
    r1s     = w[9:7];
    r2s     = w[4:2];
    exp_len = 0;
    if ((w[1:0] == 2'b10) && (w[15:13] == 3'b101)) begin
      if ((grp == 3'b011) && (w[6:5] == 2'b01) && (r1s != r2s)) begin
        push_exp(addi_word(sreg_num(int'(r1s)), 5'd10, 0));
        push_exp(addi_word(sreg_num(int'(r2s)), 5'd11, 0));
      end else if ((grp == 3'b011) && (w[6:5] == 2'b11)) begin
        push_exp(addi_word(5'd10, sreg_num(int'(r1s)), 0));
        push_exp(addi_word(5'd11, sreg_num(int'(r2s)), 0));
      end else if (grp[2:1] == 2'b11 && !w[8] && (w[7:4] >= 4'd4)) begin
        sregs  = (w[7:4] == 4'd15) ? 12 : int'(w[7:4]) - 4;
        total  = ((4 * (sregs + 1) + 15) / 16) * 16 + 16 * int'(w[3:2]);
        is_pop = !((grp == 3'b110) && !w[9]);
        // Highest s register first, then ra in the next slot down
        for (int i = 0; i <= sregs; i++) begin
          if (is_pop) begin
            push_exp(lw_word((i == sregs) ? 5'd1 : sreg_num(sregs - 1 - i),
                             total - 4 * (i + 1)));
          end else begin
            push_exp(sw_word((i == sregs) ? 5'd1 : sreg_num(sregs - 1 - i), -4 * (i + 1)));
          end
        end
        push_exp(addi_word(5'd2, 5'd2, is_pop ? total : -total));
        if ((grp == 3'b111) && !w[9]) begin
          push_exp(addi_word(5'd10, 5'd0, 0));
        end
        if (grp == 3'b111) begin
          push_exp({12'd0, 5'd1, 3'b000, 5'd0, 7'h67});
        end
      end
    end
    exp_legal = (exp_len != 0);
  endfunction

  //////////////////////////////////////////////////
  // Beat tracking, back-pressure and checks
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat <= 0;
    end else if (kill_i) begin
      beat <= 0;
    end else if (valid_o && ready_i) begin
      beat <= last_o ? 0 : beat + 1;
    end
  end

  // One LFSR bit per cycle decides ready_i
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bp_lfsr <= SEED;
      ready_i <= 1'b0;
    end else begin
      ready_i <= bp_lfsr[31];
      bp_lfsr <= lfsr_next(bp_lfsr);
    end
  end

  a_instr: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && ready_i) |-> (beat < exp_len && instr_o == exp_mem[beat]))
    else begin
      value_errs++;
      $display("FAIL %s beat %0d: expected %h actual %h", test_name, beat, exp_mem[beat],
               instr_o);
    end

  a_first: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> (first_o == (beat == 0)))
    else begin
      flag_errs++;
      $display("FAIL %s first_o beat %0d: expected %b actual %b", test_name, beat,
               beat == 0, first_o);
    end

  a_last: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> (last_o == (beat == exp_len - 1)))
    else begin
      flag_errs++;
      $display("FAIL %s last_o beat %0d: expected %b actual %b", test_name, beat,
               beat == exp_len - 1, last_o);
    end

  a_legal: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && !kill_i) |-> (valid_o == exp_legal))
    else begin
      hs_errs++;
      $display("FAIL %s valid_o: expected %b actual %b", test_name, exp_legal, valid_o);
    end

  // Illegal words are consumed at once
  a_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && !exp_legal) |-> ready_o)
    else begin
      hs_errs++;
      $display("FAIL %s ready_o on illegal word: expected 1 actual %b", test_name, ready_o);
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && !ready_i) |=> ($stable(instr_o) && $stable(first_o) && $stable(last_o)))
    else begin
      hs_errs++;
      $display("%s: output beat changed while the consumer stalled", test_name);
    end

  // Input word is taken only when the final beat of the model transfers
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> (ready_o == (ready_i && (beat == exp_len - 1))))
    else begin
      hs_errs++;
      $display("FAIL %s ready_o: expected %b actual %b", test_name,
               ready_i && (beat == exp_len - 1), ready_o);
    end

  a_kill: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> (!valid_o && ready_o))
    else begin
      hs_errs++;
      $display("%s: kill did not drop the output beat", test_name);
    end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Offer one word and hold it until the DUT takes it
  task automatic run_word(input string name, input logic [15:0] w);
    int cycles;
    @(negedge clk);
    test_name = name;
    build_expected(w);
    @(posedge clk);
    instr_i <= w;
    valid_i <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!ready_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready_o) begin
      timeout_errs++;
      $display("%s: word %h was never accepted", name, w);
    end
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    int          cycles;
    rst_n        = 1'b0;
    instr_i      = '0;
    valid_i      = 1'b0;
    kill_i       = 1'b0;
    exp_len      = 0;
    exp_legal    = 1'b0;
    test_name    = "reset";
    value_errs   = 0;
    flag_errs    = 0;
    hs_errs      = 0;
    timeout_errs = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Random rlist 4..15 and spimm for each stack instruction
    for (int k = 0; k < 24; k++) begin
      rand_bits(4, r);
      rand_bits(2, s);
      case (k % 4)
        0: run_word("push", pp_word(3'b110, 2'b00, 4'(4 + r % 12), s[1:0]));
        1: run_word("pop", pp_word(3'b110, 2'b10, 4'(4 + r % 12), s[1:0]));
        2: run_word("popret", pp_word(3'b111, 2'b10, 4'(4 + r % 12), s[1:0]));
        default: run_word("popretz", pp_word(3'b111, 2'b00, 4'(4 + r % 12), s[1:0]));
      endcase
    end

    // Double moves
    // mvsa01 needs two different targets
    for (int k = 0; k < 8; k++) begin
      rand_bits(3, r);
      rand_bits(3, s);
      run_word("mva01s", mv_word(2'b11, r[2:0], s[2:0]));
      if (r[2:0] == s[2:0]) begin
        s[0] = ~s[0];
      end
      run_word("mvsa01", mv_word(2'b01, r[2:0], s[2:0]));
    end
    run_word("mvsa01 same reg", mv_word(2'b01, 3'd3, 3'd3));

    // Reserved rlist and words outside the Zc group
    for (int k = 0; k < 4; k++) begin
      run_word("reserved rlist", pp_word(3'b110, 2'b00, 4'(k), 2'd0));
    end
    run_word("c.nop", 16'h0001);
    run_word("c.lwsp", 16'h4082);
    run_word("bad push sub", pp_word(3'b110, 2'b01, 4'd8, 2'd0));

    // Kill part way through a long popret and replay it afterwards
    @(negedge clk);
    test_name = "kill";
    build_expected(pp_word(3'b111, 2'b10, 4'd15, 2'd1));
    @(posedge clk);
    instr_i <= pp_word(3'b111, 2'b10, 4'd15, 2'd1);
    valid_i <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (beat < 3 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (beat < 3) begin
      timeout_errs++;
      $display("kill: sequence never reached beat 3");
    end
    @(posedge clk);
    kill_i <= 1'b1;
    @(posedge clk);
    kill_i  <= 1'b0;
    valid_i <= 1'b0;
    run_word("after kill", pp_word(3'b111, 2'b10, 4'd15, 2'd1));

    $display("errors: value %0d, flag %0d, handshake %0d, timeout %0d",
             value_errs, flag_errs, hs_errs, timeout_errs);
    if (value_errs + flag_errs + hs_errs + timeout_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
zc_seq_pkg.sv
zc_seq_decoder.sv
zc_seq_counter.sv
zc_seq_fsm.sv
zc_seq_emitter.sv
zc_sequencer.sv
tb_zc_sequencer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_zc_sequencer -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_zc_sequencer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
